/* Makefile */
# Verilator simulation of the radio housekeeping controller

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module radio_ctrl_tb -Mdir obj_dir
	./obj_dir/Vradio_ctrl_tb | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/radio_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module radio_ctrl_tb
  import radio_ctrl_pkg::*;
();

  // About 42 ms of debounce waits at 2504 cycles each and ~110 short requests
  localparam int CYCLE_LIMIT = 200000;

  logic        clk = 1'b0;
  logic        slow_adc_rst;
  logic        cmd_rqst_i;
  cmd_addr_t   cmd_addr_i;
  cmd_data_t   cmd_data_i;
  logic        tx_on_i, cw_on_i, run_i, rxclip_i, resp_rqst_i;
  logic        io_phone_tip_i, io_phone_ring_i, io_tx_inhibit_i;
  adc_sample_t temperature_i, fwd_pwr_i, rev_pwr_i, bias_current_i;
  logic        qmsec_pulse_o, msec_pulse_o, cw_keydown_o, fan_pwm_o;
  resp_word_t  resp_o;
  logic        pa_inttr_o, pa_exttr_o, pwr_envpa_o, pwr_envop_o;
  logic        pwr_envbias_o, rffe_rfsw_sel_o;

  // Reference copy of the last accepted PA configuration
  logic        exp_vna, exp_pa_en, exp_trdis;
  slot_t       exp_slot;

  int          seq_errs = 0;
  int          tick_errs = 0;
  int          prop_errs = 0;
  int          cycles = 0;
  int          q_gap, q_between;
  logic        q_seen, m_seen;
  logic        tip_hold;
  logic [31:0] lfsr = 32'd94669;

  always #50 clk = ~clk;

  radio_ctrl_top i_radio_ctrl_top (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      seq_errs = seq_errs + 1;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic expect_word(input string name, input logic [39:0] got,
                             input logic [39:0] exp);
    assert (got === exp) else begin
      seq_errs = seq_errs + 1;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Tick spacing and quarter strobes between millisecond strobes
  always @(negedge clk) begin
    if (slow_adc_rst) begin
      q_gap     = 0;
      q_between = 0;
      q_seen    = 1'b0;
      m_seen    = 1'b0;
    end else begin
      q_gap = q_gap + 1;
      if (qmsec_pulse_o) begin
        if (q_seen) begin
          assert (q_gap == int'(`QMSEC_RELOAD) + 1) else begin
            tick_errs = tick_errs + 1;
            $display("[ERROR] %0t qmsec_pulse_o spacing got %0d expected %0d",
                     $time, q_gap, int'(`QMSEC_RELOAD) + 1);
          end
        end
        q_gap  = 0;
        q_seen = 1'b1;
        if (msec_pulse_o) begin
          if (m_seen) begin
            assert (q_between == 3) else begin
              tick_errs = tick_errs + 1;
              $display("[ERROR] %0t qmsec pulses between msec_pulse_o got %0d expected 3",
                       $time, q_between);
            end
          end
          q_between = 0;
          m_seen    = 1'b1;
        end else begin
          q_between = q_between + 1;
        end
      end
    end
  end

  msec_with_qmsec: assert property (@(posedge clk) disable iff (slow_adc_rst)
    msec_pulse_o |-> qmsec_pulse_o)
  else begin
    prop_errs = prop_errs + 1;
    $display("[ERROR] %0t msec_pulse_o got 1 while qmsec_pulse_o got 0", $time);
  end

  // Nothing keys the transmitter while the radio is not running
  idle_no_tx: assert property (@(posedge clk) disable iff (slow_adc_rst)
    !run_i |-> !(pa_inttr_o | pa_exttr_o | pwr_envpa_o | pwr_envop_o | pwr_envbias_o))
  else begin
    prop_errs = prop_errs + 1;
    $display("Transmit output active at %0t although run_i is low", $time);
  end

  // A short release of the tip must never reach cw_keydown_o
  tip_glitch_hold: assert property (@(posedge clk) disable iff (slow_adc_rst)
    tip_hold |-> cw_keydown_o)
  else begin
    prop_errs = prop_errs + 1;
    $display("[ERROR] %0t cw_keydown_o got 0 expected 1", $time);
  end

  task automatic check_keying(input logic txon);
    logic pa_path;
    pa_path = ~exp_vna & exp_pa_en;
    expect_bit("pwr_envop_o", pwr_envop_o, txon);
    expect_bit("pa_exttr_o", pa_exttr_o, txon);
    expect_bit("pwr_envpa_o", pwr_envpa_o, txon & pa_path);
    expect_bit("pwr_envbias_o", pwr_envbias_o, txon & pa_path);
    expect_bit("pa_inttr_o", pa_inttr_o, txon & ~exp_vna & (exp_pa_en | ~exp_trdis));
    expect_bit("rffe_rfsw_sel_o", rffe_rfsw_sel_o, pa_path);
  endtask

  task automatic write_cmd(input cmd_addr_t addr, input cmd_data_t data);
    @(posedge clk);
    cmd_rqst_i <= 1'b1;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
    if (addr == `CMD_ADDR_PA) begin
      exp_vna   = data[`PA_BIT_VNA];
      exp_pa_en = data[`PA_BIT_ENABLE];
      exp_trdis = data[`PA_BIT_TRDIS];
    end
  endtask

  task automatic wait_msec(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      while (!msec_pulse_o) begin
        @(negedge clk);
      end
    end
  endtask

  // Random clip burst followed by one request with tip and ring released
  task automatic issue_request(input adc_sample_t temp);
    int          clips;
    logic        ptt;
    logic [31:0] payload;
    clips = int'(rand_bits(3)) % 6;
    ptt   = 1'(rand_bits(1));
    @(posedge clk);
    temperature_i  <= temp;
    fwd_pwr_i      <= 12'(rand_bits(12));
    rev_pwr_i      <= 12'(rand_bits(12));
    bias_current_i <= 12'(rand_bits(12));
    cw_on_i        <= ptt;
    rxclip_i       <= (clips > 0);
    for (int i = 1; i < clips; i++) begin
      @(posedge clk);
    end
    @(posedge clk);
    rxclip_i <= 1'b0;
    repeat (2) @(posedge clk);
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    resp_rqst_i <= 1'b0;
    @(negedge clk);
    case (exp_slot)
      2'd0:    payload = {7'h0F, (clips >= 3), 16'h0000, `VERSION_MAJOR};
      2'd1:    payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: payload = 32'h0000_0000;
    endcase
    expect_word("resp_o slot", 40'(resp_o[36:35]), 40'(exp_slot));
    expect_word("resp_o", resp_o, {3'b000, exp_slot, 1'b0, 1'b0, ptt, payload});
    exp_slot = exp_slot + 2'd1;
  endtask

  initial begin
    cmd_addr_t addr;
    logic      run;
    slow_adc_rst    <= 1'b1;
    cmd_rqst_i      <= 1'b0;
    cmd_addr_i      <= '0;
    cmd_data_i      <= '0;
    tx_on_i         <= 1'b0;
    cw_on_i         <= 1'b0;
    run_i           <= 1'b0;
    rxclip_i        <= 1'b0;
    resp_rqst_i     <= 1'b0;
    io_phone_tip_i  <= 1'b1;
    io_phone_ring_i <= 1'b1;
    io_tx_inhibit_i <= 1'b1;
    temperature_i   <= '0;
    fwd_pwr_i       <= '0;
    rev_pwr_i       <= '0;
    bias_current_i  <= '0;
    tip_hold        <= 1'b0;
    exp_vna   = 1'b0;
    exp_pa_en = 1'b0;
    exp_trdis = 1'b0;
    exp_slot  = 2'd0;
    repeat (4) @(posedge clk);
    slow_adc_rst <= 1'b0;

    @(negedge clk);
    check_keying(1'b0);
    expect_bit("fan_pwm_o", fan_pwm_o, 1'b0);
    expect_bit("cw_keydown_o", cw_keydown_o, 1'b0);
    expect_word("resp_o", resp_o, {32'h0000_0000, `VERSION_MAJOR});

    // PA configuration with some writes to foreign addresses
    @(posedge clk);
    tx_on_i <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      if (rand_bits(2) == 32'd0) begin
        addr = 6'(rand_bits(6));
        if (addr == `CMD_ADDR_PA) begin
          addr = ~addr;
        end
      end else begin
        addr = `CMD_ADDR_PA;
      end
      run = 1'(rand_bits(1));
      @(posedge clk);
      run_i <= run;
      write_cmd(addr, rand_bits(32));
      @(negedge clk);
      check_keying(run);
    end
    @(posedge clk);
    run_i <= 1'b1;
    write_cmd(`CMD_ADDR_PA, 32'd1 << `PA_BIT_ENABLE);
    @(negedge clk);
    check_keying(1'b1);

    // Front panel inputs through the debouncers
    @(posedge clk);
    io_tx_inhibit_i <= 1'b0;
    wait_msec(6);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b0);
    @(posedge clk);
    io_tx_inhibit_i <= 1'b1;
    wait_msec(6);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b1);
    @(posedge clk);
    tx_on_i         <= 1'b0;
    io_phone_ring_i <= 1'b0;
    wait_msec(6);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b1);
    @(posedge clk);
    io_phone_ring_i <= 1'b1;
    wait_msec(6);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b0);
    @(posedge clk);
    io_phone_tip_i <= 1'b0;
    wait_msec(6);
    expect_bit("cw_keydown_o", cw_keydown_o, 1'b1);
    // Release shorter than one millisecond
    @(posedge clk);
    io_phone_tip_i <= 1'b1;
    tip_hold       <= 1'b1;
    repeat (1000) @(posedge clk);
    io_phone_tip_i <= 1'b0;
    wait_msec(6);
    expect_bit("cw_keydown_o", cw_keydown_o, 1'b1);
    @(posedge clk);
    tip_hold       <= 1'b0;
    io_phone_tip_i <= 1'b1;
    wait_msec(6);
    expect_bit("cw_keydown_o", cw_keydown_o, 1'b0);

    for (int i = 0; i < 8; i++) begin
      issue_request(12'(rand_bits(12)));
    end

    // Hot enough to climb all the way to overheat
    @(posedge clk);
    tx_on_i <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      issue_request({1'b1, 11'(rand_bits(11))});
    end
    @(negedge clk);
    expect_bit("fan_pwm_o", fan_pwm_o, 1'b1);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b0);
    for (int i = 0; i < 60; i++) begin
      issue_request({3'b000, 9'(rand_bits(9))});
    end
    @(negedge clk);
    expect_bit("fan_pwm_o", fan_pwm_o, 1'b0);
    expect_bit("pa_exttr_o", pa_exttr_o, 1'b1);

    $display("Errors: sequence %0d, ticks %0d, properties %0d",
             seq_errs, tick_errs, prop_errs);
    if (seq_errs + tick_errs + prop_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/radio_ctrl_pkg.sv
hdl/ctrl_tick_gen.sv
hdl/key_debounce.sv
hdl/tx_keying.sv
hdl/fan_thermal_ctrl.sv
hdl/telemetry_resp.sv
hdl/radio_ctrl_top.sv
dv/radio_ctrl_tb.sv

/* hdl/ctrl_tick_gen.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module ctrl_tick_gen (
  input  logic clk,
  input  logic slow_adc_rst,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  logic [9:0] qmsec_cnt;
  logic [1:0] msec_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      qmsec_cnt     <= `QMSEC_RELOAD;
      msec_cnt      <= 2'd0;
      qmsec_pulse_o <= 1'b0;
      msec_pulse_o  <= 1'b0;
    end else begin
      qmsec_pulse_o <= 1'b0;
      msec_pulse_o  <= 1'b0;
      if (qmsec_cnt == 10'd0) begin
        qmsec_cnt     <= `QMSEC_RELOAD;
        qmsec_pulse_o <= 1'b1;
        msec_cnt      <= msec_cnt + 2'd1;
        // Every fourth reload marks a full millisecond
        if (msec_cnt == 2'd3) begin
          msec_pulse_o <= 1'b1;
        end
      end else begin
        qmsec_cnt <= qmsec_cnt - 10'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/fan_thermal_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module fan_thermal_ctrl
  import radio_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        slow_adc_rst,
  input  logic        adc_sample_i,
  input  adc_sample_t temperature_i,
  output logic        fan_pwm_o,
  output logic        temp_enable_tx_o
);

  fan_state_e  fan_state;
  fan_state_e  fan_state_next;
  logic [1:0]  up_vote;
  logic [1:0]  up_vote_next;
  logic [1:0]  dn_vote;
  logic [1:0]  dn_vote_next;
  logic [15:0] fan_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      fan_state <= FAN_OFF;
      up_vote   <= 2'd0;
      dn_vote   <= 2'd0;
      fan_cnt   <= 16'd0;
    end else begin
      fan_cnt <= fan_cnt + 16'd1;
      if (adc_sample_i) begin
        fan_state <= fan_state_next;
        up_vote   <= up_vote_next;
        dn_vote   <= dn_vote_next;
      end
    end
  end

  // Votes decay unless this sample agrees; a full vote moves one step
  always_comb begin
    fan_state_next = fan_state;
    up_vote_next   = (up_vote == 2'd0) ? 2'd0 : up_vote - 2'd1;
    dn_vote_next   = (dn_vote == 2'd0) ? 2'd0 : dn_vote - 2'd1;
    fan_pwm_o      = 1'b0;

    unique case (fan_state)
      FAN_OFF: begin
        if (temperature_i > `TEMP_35C) up_vote_next = up_vote + 2'd1;
        if (&up_vote) fan_state_next = FAN_LOW;
      end
      FAN_LOW: begin
        if (temperature_i > `TEMP_40C) up_vote_next = up_vote + 2'd1;
        else if (temperature_i < `TEMP_30C) dn_vote_next = dn_vote + 2'd1;
        if (&up_vote) fan_state_next = FAN_MED;
        else if (&dn_vote) fan_state_next = FAN_OFF;
        fan_pwm_o = fan_cnt[15];
      end
      FAN_MED: begin
        if (temperature_i > `TEMP_45C) up_vote_next = up_vote + 2'd1;
        else if (temperature_i < `TEMP_35C) dn_vote_next = dn_vote + 2'd1;
        if (&up_vote) fan_state_next = FAN_FULL;
        else if (&dn_vote) fan_state_next = FAN_LOW;
        // Three quarters duty
        fan_pwm_o = fan_cnt[15] | fan_cnt[14];
      end
      FAN_FULL: begin
        if (temperature_i > `TEMP_55C) up_vote_next = up_vote + 2'd1;
        else if (temperature_i < `TEMP_40C) dn_vote_next = dn_vote + 2'd1;
        if (&up_vote) fan_state_next = FAN_OVERHEAT;
        else if (&dn_vote) fan_state_next = FAN_MED;
        fan_pwm_o = 1'b1;
      end
      FAN_OVERHEAT: begin
        if (temperature_i < `TEMP_50C) dn_vote_next = dn_vote + 2'd1;
        if (&dn_vote) fan_state_next = FAN_FULL;
        fan_pwm_o = 1'b1;
      end
      default: begin
        fan_state_next = FAN_OFF;
      end
    endcase
  end

  // Too hot to transmit
  assign temp_enable_tx_o = (fan_state != FAN_OVERHEAT);

endmodule

`default_nettype wire

/* hdl/key_debounce.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module key_debounce (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic msec_pulse_i,
  input  logic pin_n_i,
  output logic clean_o
);

  logic       pin_meta;
  logic       pin_sync;
  logic [2:0] stable_cnt;

  // Pin is asynchronous to clk
  always_ff @(posedge clk) begin
    pin_meta <= pin_n_i;
    pin_sync <= pin_meta;
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      stable_cnt <= 3'd0;
      clean_o    <= 1'b0;
    end else if (~pin_sync == clean_o) begin
      // Bounced back, start over
      stable_cnt <= 3'd0;
    end else if (msec_pulse_i) begin
      if (stable_cnt == `DEBOUNCE_MS - 3'd1) begin
        clean_o    <= ~pin_sync;
        stable_cnt <= 3'd0;
      end else begin
        stable_cnt <= stable_cnt + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/radio_ctrl_macros.svh */
`ifndef RADIO_CTRL_MACROS_SVH
`define RADIO_CTRL_MACROS_SVH

// Firmware version reported in telemetry slot 0
`define VERSION_MAJOR 8'h4A

// Quarter millisecond is QMSEC_RELOAD + 1 clk cycles
`define QMSEC_RELOAD 10'd625

// Millisecond strobes an input must hold before it is accepted
`define DEBOUNCE_MS 3'd4

// Command address of the PA configuration word
`define CMD_ADDR_PA 6'h09

// Slow ADC temperature codes, ((T*0.01)+0.5)/3.26*4096
`define TEMP_30C 12'h3ED
`define TEMP_35C 12'h42B
`define TEMP_40C 12'h46B
`define TEMP_45C 12'h4AA
`define TEMP_50C 12'h4E8
`define TEMP_55C 12'h527

// Field positions inside the PA command data
`define PA_BIT_VNA    23
`define PA_BIT_ENABLE 19
`define PA_BIT_TRDIS  18

`endif

/* hdl/radio_ctrl_pkg.sv */
`default_nettype none

package radio_ctrl_pkg;

  // Command bus fields
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // One reading from the slow ADC
  typedef logic [11:0] adc_sample_t;

  // Telemetry slot number and response word
  typedef logic [1:0]  slot_t;
  typedef logic [39:0] resp_word_t;

  // Fan speed states, Gray-like so neighbours differ in one bit
  typedef enum logic [2:0] {
    FAN_OFF      = 3'b000,
    FAN_LOW      = 3'b001,
    FAN_MED      = 3'b011,
    FAN_FULL     = 3'b010,
    FAN_OVERHEAT = 3'b110
  } fan_state_e;

endpackage

`default_nettype wire

/* hdl/radio_ctrl_top.sv */
`default_nettype none
`timescale 1ns/1ps

module radio_ctrl_top
  import radio_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        slow_adc_rst,
  input  logic        cmd_rqst_i,
  input  cmd_addr_t   cmd_addr_i,
  input  cmd_data_t   cmd_data_i,
  input  logic        tx_on_i,
  input  logic        cw_on_i,
  input  logic        run_i,
  input  logic        rxclip_i,
  input  logic        resp_rqst_i,
  input  logic        io_phone_tip_i,
  input  logic        io_phone_ring_i,
  input  logic        io_tx_inhibit_i,
  input  adc_sample_t temperature_i,
  input  adc_sample_t fwd_pwr_i,
  input  adc_sample_t rev_pwr_i,
  input  adc_sample_t bias_current_i,
  output logic        qmsec_pulse_o,
  output logic        msec_pulse_o,
  output logic        cw_keydown_o,
  output resp_word_t  resp_o,
  output logic        fan_pwm_o,
  output logic        pa_inttr_o,
  output logic        pa_exttr_o,
  output logic        pwr_envpa_o,
  output logic        pwr_envop_o,
  output logic        pwr_envbias_o,
  output logic        rffe_rfsw_sel_o
);

  logic msec_pulse;
  logic key_tip;
  logic key_ring;
  logic ext_inhibit;
  logic adc_sample;
  logic temp_enable_tx;
  logic ptt_flag;

  assign msec_pulse_o = msec_pulse;
  assign cw_keydown_o = key_tip;

  // Ring doubles as PTT in basic CW mode
  assign ptt_flag = cw_on_i | key_ring;

  ctrl_tick_gen u_tick (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .qmsec_pulse_o (qmsec_pulse_o),
    .msec_pulse_o  (msec_pulse)
  );

  key_debounce u_tip (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse),
    .pin_n_i      (io_phone_tip_i),
    .clean_o      (key_tip)
  );

  key_debounce u_ring (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse),
    .pin_n_i      (io_phone_ring_i),
    .clean_o      (key_ring)
  );

  key_debounce u_inhibit (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse),
    .pin_n_i      (io_tx_inhibit_i),
    .clean_o      (ext_inhibit)
  );

  tx_keying u_keying (
    .clk              (clk),
    .slow_adc_rst     (slow_adc_rst),
    .cmd_rqst_i       (cmd_rqst_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_data_i       (cmd_data_i),
    .tx_on_i          (tx_on_i),
    .ext_ptt_i        (key_ring),
    .ext_inhibit_i    (ext_inhibit),
    .run_i            (run_i),
    .temp_enable_tx_i (temp_enable_tx),
    .pa_inttr_o       (pa_inttr_o),
    .pa_exttr_o       (pa_exttr_o),
    .pwr_envpa_o      (pwr_envpa_o),
    .pwr_envop_o      (pwr_envop_o),
    .pwr_envbias_o    (pwr_envbias_o),
    .rffe_rfsw_sel_o  (rffe_rfsw_sel_o)
  );

  fan_thermal_ctrl u_fan (
    .clk              (clk),
    .slow_adc_rst     (slow_adc_rst),
    .adc_sample_i     (adc_sample),
    .temperature_i    (temperature_i),
    .fan_pwm_o        (fan_pwm_o),
    .temp_enable_tx_o (temp_enable_tx)
  );

  telemetry_resp u_telemetry (
    .clk            (clk),
    .slow_adc_rst   (slow_adc_rst),
    .resp_rqst_i    (resp_rqst_i),
    .rxclip_i       (rxclip_i),
    .key_tip_i      (key_tip),
    .ptt_flag_i     (ptt_flag),
    .temperature_i  (temperature_i),
    .fwd_pwr_i      (fwd_pwr_i),
    .rev_pwr_i      (rev_pwr_i),
    .bias_current_i (bias_current_i),
    .resp_o         (resp_o),
    .adc_sample_o   (adc_sample)
  );

endmodule

`default_nettype wire

/* hdl/telemetry_resp.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module telemetry_resp
  import radio_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        slow_adc_rst,
  input  logic        resp_rqst_i,
  input  logic        rxclip_i,
  input  logic        key_tip_i,
  input  logic        ptt_flag_i,
  input  adc_sample_t temperature_i,
  input  adc_sample_t fwd_pwr_i,
  input  adc_sample_t rev_pwr_i,
  input  adc_sample_t bias_current_i,
  output resp_word_t  resp_o,
  output logic        adc_sample_o
);

  slot_t       slot;
  logic        sample_tgl;
  logic [1:0]  clip_cnt;
  logic        clip_flag;
  logic [31:0] payload;

  assign clip_flag = &clip_cnt;

  always_comb begin
    unique case (slot)
      2'd0:    payload = {7'h0F, clip_flag, 16'h0000, `VERSION_MAJOR};
      2'd1:    payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: payload = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      slot       <= 2'd0;
      sample_tgl <= 1'b0;
      clip_cnt   <= 2'd0;
      resp_o     <= {32'h0000_0000, `VERSION_MAJOR};
    end else if (resp_rqst_i) begin
      slot       <= slot + 2'd1;
      sample_tgl <= ~sample_tgl;
      clip_cnt   <= 2'd0;
      resp_o     <= {3'b000, slot, key_tip_i, 1'b0, ptt_flag_i, payload};
    end else if (!clip_flag) begin
      // Saturates at 3 until the next request
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  // Slow ADC sampled on every other request
  assign adc_sample_o = resp_rqst_i & sample_tgl;

endmodule

`default_nettype wire

/* hdl/tx_keying.sv */
`default_nettype none
`timescale 1ns/1ps

`include "radio_ctrl_macros.svh"

module tx_keying
  import radio_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      slow_adc_rst,
  input  logic      cmd_rqst_i,
  input  cmd_addr_t cmd_addr_i,
  input  cmd_data_t cmd_data_i,
  input  logic      tx_on_i,
  input  logic      ext_ptt_i,
  input  logic      ext_inhibit_i,
  input  logic      run_i,
  input  logic      temp_enable_tx_i,
  output logic      pa_inttr_o,
  output logic      pa_exttr_o,
  output logic      pwr_envpa_o,
  output logic      pwr_envop_o,
  output logic      pwr_envbias_o,
  output logic      rffe_rfsw_sel_o
);

  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic int_tx_on;
  logic pa_path;

  // PA configuration from host command
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
    end else if (cmd_rqst_i && (cmd_addr_i == `CMD_ADDR_PA)) begin
      vna        <= cmd_data_i[`PA_BIT_VNA];
      pa_enable  <= cmd_data_i[`PA_BIT_ENABLE];
      tr_disable <= cmd_data_i[`PA_BIT_TRDIS];
    end
  end

  // Keyed by host or external PTT, unless inhibited or too hot
  assign int_tx_on = (tx_on_i | ext_ptt_i) & ~ext_inhibit_i & run_i & temp_enable_tx_i;

  // RF routed through the PA only outside VNA mode
  assign pa_path = ~vna & pa_enable;

  assign pwr_envop_o     = int_tx_on;
  assign pa_exttr_o      = int_tx_on;
  assign pwr_envpa_o     = int_tx_on & pa_path;
  assign pwr_envbias_o   = int_tx_on & pa_path;
  assign pa_inttr_o      = int_tx_on & ~vna & (pa_enable | ~tr_disable);
  assign rffe_rfsw_sel_o = pa_path;

endmodule

`default_nettype wire
